// File: vlog.f
source/exu_pkg.sv
source/exu_op_if.sv
source/id_ex_reg.sv
source/exu_operand_decode.sv
source/exu_alu.sv
source/exu_result_select.sv
source/exu_top.sv
sim/clk_gen.sv
sim/exu_tb.sv

// File: sim/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int max_rows = 96;
    localparam int reset_cycles = 5;
    // instruction bit 30 as it sits in imm
    localparam xword_t alt_bit = 64'h400;
    localparam xword_t msb = 64'h8000_0000_0000_0000;
    localparam xword_t neg_word = 64'h0000_0000_8000_0000;

    // one instruction, its bypass state and what the stage should give back
    typedef struct packed {
        logic [3:0] cls;
        funct3_t f3;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xword_t pc;
        xword_t a;
        xword_t b;
        xword_t imm;
        logic mem_we;
        reg_idx_t mem_rd;
        xword_t mem_data;
        logic wb_we;
        reg_idx_t wb_rd;
        xword_t wb_data;
        logic [3:0] stall;
        logic flush;
        logic exp_valid;
        logic exp_pc_update;
        xword_t exp_result;
        xword_t exp_dnpc;
    } row_t;

    logic clk;
    logic rst_n;
    logic valid_id_ex, ready_id_ex, valid_ex_mem, ready_ex_mem;
    logic mem_writing_gpr, wb_writing_gpr, branch_flush, pc_update;
    xword_t pc_id_ex, src_a, src_b, imm_in, pc_ex_mem, result, dnpc;
    xword_t mem_data, wb_data;
    inst_t inst_id_ex, inst_ex_mem;
    inst_class_e inst_class_id_ex;
    funct3_t funct3_id_ex;
    reg_idx_t rd_id_ex, rs1_id_ex, rs2_id_ex, rd_ex_mem, mem_rd, wb_rd;

    row_t rows [max_rows];
    int n_rows = 0;
    int cycles = 0;
    int cycle_limit = 0;
    integer seed = 30737;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exu_top dut0 (.*);

    function automatic xword_t rnd64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xword_t simm12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // mem beats wb beats the register file and x0 is never bypassed
    function automatic xword_t bypassed(input row_t r, input reg_idx_t rs, input xword_t regval);
        if (rs != 5'd0 && r.mem_we && r.mem_rd == rs)
            return r.mem_data;
        if (rs != 5'd0 && r.wb_we && r.wb_rd == rs)
            return r.wb_data;
        return regval;
    endfunction

    // full width op where sub only exists in the register form
    function automatic xword_t arith64(input funct3_t f3, input logic alt, input logic reg_form,
                                       input xword_t a, input xword_t b);
        xword_t res;
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'd0: res = (alt && reg_form) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: res = (a < b) ? 64'd1 : 64'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt)
                    res = $signed(a) >>> sh;
                else
                    res = a >> sh;
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // 32-bit op on the low words then sign extended
    function automatic xword_t word32(input funct3_t f3, input logic alt, input logic reg_form,
                                      input xword_t a, input xword_t b);
        logic [31:0] a32;
        logic [31:0] w;
        logic [4:0] sh;
        a32 = a[31:0];
        sh = b[4:0];
        case (f3)
            3'd0: w = (alt && reg_form) ? a32 - b[31:0] : a32 + b[31:0];
            3'd1: w = a32 << sh;
            3'd5: begin
                if (alt)
                    w = $signed(a32) >>> sh;
                else
                    w = a32 >> sh;
            end
            default: w = '0;
        endcase
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input xword_t s1, input xword_t s2);
        case (f3)
            f3_beq:  return s1 == s2;
            f3_bne:  return s1 != s2;
            f3_blt:  return $signed(s1) < $signed(s2);
            f3_bge:  return $signed(s1) >= $signed(s2);
            f3_bltu: return s1 < s2;
            f3_bgeu: return s1 >= s2;
            default: return 1'b0;
        endcase
    endfunction

    // reference model for one row
    task automatic compute_expected(input int i);
        row_t r;
        xword_t s1;
        xword_t s2;
        logic alt;
        logic taken;
        logic redirect;
        r = rows[i];
        alt = r.imm[10];
        s1 = bypassed(r, r.rs1, r.a);
        // rs2 only read by branch, op and op_w
        if (r.cls == cls_branch || r.cls == cls_op || r.cls == cls_op_w)
            s2 = bypassed(r, r.rs2, r.b);
        else
            s2 = r.b;
        case (r.cls)
            cls_lui:      r.exp_result = r.imm;
            cls_auipc:    r.exp_result = r.pc + r.imm;
            cls_jal:      r.exp_result = r.pc + 64'd4;
            cls_jalr:     r.exp_result = r.pc + 64'd4;
            cls_branch:   r.exp_result = s1 - s2;
            cls_op_imm:   r.exp_result = arith64(r.f3, alt, 1'b0, s1, r.imm);
            cls_op:       r.exp_result = arith64(r.f3, alt, 1'b1, s1, s2);
            cls_op_imm_w: r.exp_result = word32(r.f3, alt, 1'b0, s1, r.imm);
            cls_op_w:     r.exp_result = word32(r.f3, alt, 1'b1, s1, s2);
            default:      r.exp_result = '0;
        endcase
        taken = branch_taken(r.f3, s1, s2);
        // backward branches predicted taken
        redirect = (r.cls == cls_jal) || (r.cls == cls_jalr) ||
                   ((r.cls == cls_branch) && (taken != r.imm[63]));
        if (r.cls == cls_jalr)
            r.exp_dnpc = (s1 + r.imm) & ~64'd1;
        else if (r.cls == cls_jal || (r.cls == cls_branch && taken))
            r.exp_dnpc = r.pc + r.imm;
        else
            r.exp_dnpc = r.pc + 64'd4;
        r.exp_valid = !r.flush;
        r.exp_pc_update = r.exp_valid && (r.stall == 0) && redirect;
        rows[i] = r;
    endtask

    task automatic new_row(input inst_class_e cls, input funct3_t f3, input reg_idx_t rs1,
                           input reg_idx_t rs2, input xword_t a, input xword_t b,
                           input xword_t imm);
        row_t r;
        r = '0;
        r.cls = cls;
        r.f3 = f3;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.rd = reg_idx_t'(n_rows);
        r.pc = 64'h0000_0000_8000_0000 + 64'(n_rows * 4);
        r.a = a;
        r.b = b;
        r.imm = imm;
        rows[n_rows] = r;
        n_rows++;
    endtask

    // bypass state with random data for the last row
    task automatic set_bypass(input logic mem_we, input reg_idx_t m_rd, input logic wb_we,
                              input reg_idx_t w_rd);
        rows[n_rows-1].mem_we = mem_we;
        rows[n_rows-1].mem_rd = m_rd;
        rows[n_rows-1].mem_data = rnd64();
        rows[n_rows-1].wb_we = wb_we;
        rows[n_rows-1].wb_rd = w_rd;
        rows[n_rows-1].wb_data = rnd64();
    endtask

    task automatic build_table();
        xword_t a;
        int f;
        int d;
        int e;
        // register forms then sub, sra and the widest shifts
        for (f = 0; f < 8; f++)
            new_row(cls_op, funct3_t'(f), 5'd1, 5'd2, rnd64(), rnd64(), '0);
        new_row(cls_op, 3'd0, 5'd1, 5'd2, rnd64(), rnd64(), alt_bit);
        new_row(cls_op, f3_sr, 5'd1, 5'd2, rnd64() | msb, rnd64(), alt_bit);
        new_row(cls_op, f3_sll, 5'd1, 5'd2, rnd64(), rnd64() | 64'h3f, '0);
        new_row(cls_op, f3_sr, 5'd1, 5'd2, rnd64() | msb, 64'h3f, alt_bit);
        // immediate forms where shifts take a plain shamt
        for (f = 0; f < 8; f++) begin
            a = rnd64();
            if (f == 1 || f == 5)
                new_row(cls_op_imm, funct3_t'(f), 5'd1, 5'd2, rnd64(), rnd64(), {58'd0, a[5:0]});
            else
                new_row(cls_op_imm, funct3_t'(f), 5'd1, 5'd2, rnd64(), rnd64(), simm12(a[11:0]));
        end
        new_row(cls_op_imm, f3_sr, 5'd1, 5'd2, rnd64() | msb, rnd64(), alt_bit | {58'd0, a[5:0]});
        new_row(cls_op_imm, f3_sll, 5'd1, 5'd2, rnd64(), rnd64(), 64'h3f);
        new_row(cls_op_imm, f3_sr, 5'd1, 5'd2, rnd64() | msb, rnd64(), 64'h3f);
        new_row(cls_op_imm, f3_sr, 5'd1, 5'd2, rnd64() | msb, rnd64(), alt_bit | 64'h3f);
        // word forms with right shifts on a negative low word
        new_row(cls_op_w, 3'd0, 5'd1, 5'd2, rnd64(), rnd64(), '0);
        new_row(cls_op_w, 3'd0, 5'd1, 5'd2, rnd64(), rnd64(), alt_bit);
        new_row(cls_op_w, f3_sll, 5'd1, 5'd2, rnd64(), rnd64(), '0);
        new_row(cls_op_w, f3_sr, 5'd1, 5'd2, rnd64() | neg_word, rnd64(), '0);
        new_row(cls_op_w, f3_sr, 5'd1, 5'd2, rnd64() | neg_word, rnd64(), alt_bit);
        a = rnd64();
        new_row(cls_op_imm_w, 3'd0, 5'd1, 5'd2, rnd64(), rnd64(), simm12(a[11:0]));
        new_row(cls_op_imm_w, f3_sll, 5'd1, 5'd2, rnd64(), rnd64(), {59'd0, a[4:0]});
        new_row(cls_op_imm_w, f3_sr, 5'd1, 5'd2, rnd64() | neg_word, rnd64(), {59'd0, a[4:0]});
        new_row(cls_op_imm_w, f3_sr, 5'd1, 5'd2, rnd64() | neg_word, rnd64(), alt_bit | 64'h1f);
        // upper immediates and jumps with an odd jalr base
        new_row(cls_lui, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), {{32{a[31]}}, a[31:12], 12'h000});
        new_row(cls_auipc, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), {{32{a[31]}}, a[31:12], 12'h000});
        new_row(cls_jal, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), simm12(12'h100));
        new_row(cls_jal, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), simm12(12'hf00));
        new_row(cls_jalr, 3'd0, 5'd1, 5'd0, rnd64() | 64'd1, rnd64(), simm12(a[11:0]));
        // six conditions in both directions on equal and random operands
        for (f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            for (d = 0; d < 2; d++) begin
                for (e = 0; e < 2; e++) begin
                    a = rnd64();
                    new_row(cls_branch, funct3_t'(f), 5'd1, 5'd2, a, (e == 1) ? a : rnd64(),
                            simm12((d == 1) ? 12'hf40 : 12'h0c0));
                end
            end
        end
        // forwarding priority and the x0 rule
        new_row(cls_op, 3'd0, 5'd5, 5'd6, rnd64(), rnd64(), '0);
        set_bypass(1'b1, 5'd5, 1'b1, 5'd5);
        new_row(cls_op, 3'd0, 5'd7, 5'd8, rnd64(), rnd64(), '0);
        set_bypass(1'b1, 5'd9, 1'b1, 5'd8);
        new_row(cls_op, 3'd0, 5'd10, 5'd10, rnd64(), rnd64(), alt_bit);
        set_bypass(1'b1, 5'd10, 1'b0, 5'd0);
        new_row(cls_op, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), '0);
        set_bypass(1'b1, 5'd0, 1'b1, 5'd0);
        new_row(cls_op_imm, 3'd0, 5'd3, 5'd4, rnd64(), rnd64(), simm12(12'h123));
        set_bypass(1'b1, 5'd4, 1'b1, 5'd3);
        a = rnd64();
        new_row(cls_branch, f3_beq, 5'd11, 5'd12, a, a, simm12(12'hf40));
        set_bypass(1'b1, 5'd12, 1'b0, 5'd0);
        new_row(cls_op, 3'd0, 5'd13, 5'd14, rnd64(), rnd64(), '0);
        set_bypass(1'b0, 5'd13, 1'b1, 5'd14);
        // held jal must not redirect while stalled
        new_row(cls_jal, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), simm12(12'h200));
        rows[n_rows-1].stall = 4'd3;
        new_row(cls_jal, 3'd0, 5'd0, 5'd0, rnd64(), rnd64(), simm12(12'h200));
        rows[n_rows-1].flush = 1'b1;
        new_row(cls_branch, f3_beq, 5'd1, 5'd2, a, a, simm12(12'h040));
        rows[n_rows-1].flush = 1'b1;
        for (f = 0; f < n_rows; f++)
            compute_expected(f);
    endtask

    task automatic check_val(input string name, input xword_t got, input xword_t exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input int i);
        row_t r;
        r = rows[i];
        check_val("valid_ex_mem", valid_ex_mem, r.exp_valid);
        check_val("pc_update", pc_update, r.exp_pc_update);
        check_val("ready_id_ex", ready_id_ex, r.stall == 0);
        // bubble payload is don't care
        if (r.exp_valid) begin
            check_val("result", result, r.exp_result);
            check_val("dnpc", dnpc, r.exp_dnpc);
            check_val("pc_ex_mem", pc_ex_mem, r.pc);
            check_val("inst_ex_mem", inst_ex_mem, 32'h0001_0000 | i);
            check_val("rd_ex_mem", rd_ex_mem, r.rd);
        end
    endtask

    task automatic apply_row(input int i);
        row_t r;
        int k;
        r = rows[i];
        @(posedge clk);
        valid_id_ex      <= 1'b1;
        pc_id_ex         <= r.pc;
        inst_id_ex       <= 32'h0001_0000 | i;
        inst_class_id_ex <= inst_class_e'(r.cls);
        funct3_id_ex     <= r.f3;
        rd_id_ex         <= r.rd;
        rs1_id_ex        <= r.rs1;
        rs2_id_ex        <= r.rs2;
        src_a            <= r.a;
        src_b            <= r.b;
        imm_in           <= r.imm;
        ready_ex_mem     <= 1'b1;
        branch_flush     <= r.flush;
        mem_writing_gpr  <= r.mem_we;
        mem_rd           <= r.mem_rd;
        mem_data         <= r.mem_data;
        wb_writing_gpr   <= r.wb_we;
        wb_rd            <= r.wb_rd;
        wb_data          <= r.wb_data;
        // captured here while bypass stays for the ex cycle
        @(posedge clk);
        valid_id_ex  <= (r.stall != 0);
        branch_flush <= 1'b0;
        ready_ex_mem <= (r.stall == 0);
        // another instruction waits upstream during the stall
        if (r.stall != 0) begin
            pc_id_ex   <= ~r.pc;
            inst_id_ex <= ~(32'h0001_0000 | i);
            rd_id_ex   <= ~r.rd;
            src_a      <= ~r.a;
            imm_in     <= ~r.imm;
        end
        @(negedge clk);
        check_outputs(i);
        for (k = 1; k <= r.stall; k++) begin
            @(negedge clk);
            check_outputs(i);
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: no finish after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "run timed out");
        end
    end

    initial begin
        int i;
        valid_id_ex = 1'b0;
        ready_ex_mem = 1'b0;
        pc_id_ex = '0;
        inst_id_ex = '0;
        inst_class_id_ex = cls_none;
        funct3_id_ex = '0;
        rd_id_ex = '0;
        rs1_id_ex = '0;
        rs2_id_ex = '0;
        src_a = '0;
        src_b = '0;
        imm_in = '0;
        mem_writing_gpr = 1'b0;
        mem_rd = '0;
        mem_data = '0;
        wb_writing_gpr = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        branch_flush = 1'b0;
        build_table();
        cycle_limit = 2 * n_rows + reset_cycles + 20;
        wait (rst_n === 1'b1);
        @(negedge clk);
        // stage empty out of reset
        check_val("valid_ex_mem", valid_ex_mem, '0);
        check_val("pc_update", pc_update, '0);
        for (i = 0; i < n_rows; i++)
            apply_row(i);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over the first five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: source/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  valid_id_ex,
    output logic                 ready_id_ex,
    input  exu_pkg::xword_t      pc_id_ex,
    input  exu_pkg::inst_t       inst_id_ex,
    input  exu_pkg::inst_class_e inst_class_id_ex,
    input  exu_pkg::funct3_t     funct3_id_ex,
    input  exu_pkg::reg_idx_t    rd_id_ex,
    input  exu_pkg::reg_idx_t    rs1_id_ex,
    input  exu_pkg::reg_idx_t    rs2_id_ex,
    input  exu_pkg::xword_t      src_a,
    input  exu_pkg::xword_t      src_b,
    input  exu_pkg::xword_t      imm_in,
    output logic                 valid_ex_mem,
    input  wire                  ready_ex_mem,
    output exu_pkg::xword_t      pc_ex_mem,
    output exu_pkg::inst_t       inst_ex_mem,
    output exu_pkg::reg_idx_t    rd_ex_mem,
    output exu_pkg::xword_t      result,
    input  wire                  mem_writing_gpr,
    input  exu_pkg::reg_idx_t    mem_rd,
    input  exu_pkg::xword_t      mem_data,
    input  wire                  wb_writing_gpr,
    input  exu_pkg::reg_idx_t    wb_rd,
    input  exu_pkg::xword_t      wb_data,
    input  wire                  branch_flush,
    output logic                 pc_update,
    output exu_pkg::xword_t      dnpc
);
    import exu_pkg::*;

    logic valid_q;
    inst_t inst_q;
    inst_class_e inst_class_q;
    funct3_t funct3_q;
    reg_idx_t rd_q;
    reg_idx_t rs1_q;
    reg_idx_t rs2_q;
    xword_t pc_q;
    xword_t src_a_q;
    xword_t src_b_q;
    xword_t imm_q;
    xword_t alu_result;

    exu_op_if op_bus ();

    // no multicycle units, the stage never stalls on its own
    assign ready_id_ex = ready_ex_mem;

    id_ex_reg u_id_ex_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_flush  (branch_flush),
        .ready_ex_mem  (ready_ex_mem),
        .valid_in      (valid_id_ex),
        .inst_in       (inst_id_ex),
        .inst_class_in (inst_class_id_ex),
        .funct3_in     (funct3_id_ex),
        .rd_in         (rd_id_ex),
        .rs1_in        (rs1_id_ex),
        .rs2_in        (rs2_id_ex),
        .pc_in         (pc_id_ex),
        .src_a_in      (src_a),
        .src_b_in      (src_b),
        .imm_in        (imm_in),
        .valid_q       (valid_q),
        .inst_q        (inst_q),
        .inst_class_q  (inst_class_q),
        .funct3_q      (funct3_q),
        .rd_q          (rd_q),
        .rs1_q         (rs1_q),
        .rs2_q         (rs2_q),
        .pc_q          (pc_q),
        .src_a_q       (src_a_q),
        .src_b_q       (src_b_q),
        .imm_q         (imm_q)
    );

    // forwarding and operand setup
    exu_operand_decode u_operand_decode (
        .valid_q         (valid_q),
        .inst_class_q    (inst_class_q),
        .funct3_q        (funct3_q),
        .rs1_q           (rs1_q),
        .rs2_q           (rs2_q),
        .pc_q            (pc_q),
        .src_a_q         (src_a_q),
        .src_b_q         (src_b_q),
        .imm_q           (imm_q),
        .mem_writing_gpr (mem_writing_gpr),
        .mem_rd          (mem_rd),
        .mem_data        (mem_data),
        .wb_writing_gpr  (wb_writing_gpr),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .op              (op_bus.decode_mp)
    );

    exu_alu u_alu (
        .op         (op_bus.use_mp),
        .alu_result (alu_result)
    );

    // writeback value and branch redirect
    exu_result_select u_result_select (
        .op           (op_bus.use_mp),
        .alu_result   (alu_result),
        .ready_ex_mem (ready_ex_mem),
        .result       (result),
        .pc_update    (pc_update),
        .dnpc         (dnpc)
    );

    // straight from the register to mem
    assign valid_ex_mem = valid_q;
    assign pc_ex_mem    = pc_q;
    assign inst_ex_mem  = inst_q;
    assign rd_ex_mem    = rd_q;

endmodule

`default_nettype wire

// File: source/exu_result_select.sv
`timescale 1ns/1ps
`default_nettype none

module exu_result_select (
    exu_op_if.use_mp         op,
    input  exu_pkg::xword_t  alu_result,
    input  wire              ready_ex_mem,
    output exu_pkg::xword_t  result,
    output logic             pc_update,
    output exu_pkg::xword_t  dnpc
);
    import exu_pkg::*;

    logic word;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic eq;
    logic lt;
    logic ltu;
    logic taken;
    logic pred_taken;
    logic mispredict;
    xword_t snpc;
    xword_t target_base;
    xword_t target;

    assign word = (op.inst_class == cls_op_imm_w) || (op.inst_class == cls_op_w);
    assign is_jal    = (op.inst_class == cls_jal);
    assign is_jalr   = (op.inst_class == cls_jalr);
    assign is_branch = (op.inst_class == cls_branch);

    assign snpc = op.pc + xword_t'(pc_step);

    // writeback value
    always_comb begin
        if (word) begin
            result = {{(xlen-32){alu_result[31]}}, alu_result[31:0]};
        end else if (is_jalr) begin
            // alu is not used for the jalr link
            result = snpc;
        end else begin
            result = alu_result;
        end
    end

    // alu holds src1 - src2 for a branch
    assign eq = (alu_result == '0);
    // signs differ means no overflow question, src1 sign decides
    assign lt = (op.src1[xlen-1] != op.src2[xlen-1]) ? op.src1[xlen-1] :
                alu_result[xlen-1];
    assign ltu = (op.src1 < op.src2);

    always_comb begin
        case (op.funct3)
            f3_beq:  taken = eq;
            f3_bne:  taken = !eq;
            f3_blt:  taken = lt;
            f3_bge:  taken = !lt;
            f3_bltu: taken = ltu;
            f3_bgeu: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // static prediction, backward taken and forward not taken
    assign pred_taken = op.imm[xlen-1];
    assign mispredict = is_branch && (taken != pred_taken);

    // one shared target adder, rs1 based for jalr
    assign target_base = is_jalr ? op.src1 : op.pc;
    assign target = target_base + op.imm;

    // only when the instruction actually leaves this cycle
    assign pc_update = op.valid && ready_ex_mem && (is_jal || is_jalr || mispredict);

    always_comb begin
        if (is_jalr) begin
            dnpc = {target[xlen-1:1], 1'b0};
        end else if (is_jal || (is_branch && taken)) begin
            dnpc = target;
        end else begin
            dnpc = snpc;
        end
    end

endmodule

`default_nettype wire

// File: source/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    exu_op_if.use_mp         op,
    output exu_pkg::xword_t  alu_result
);
    import exu_pkg::*;

    logic word;
    logic [shamt_w-1:0] sh_amt;
    xword_t shift_src;

    // word forms only look at the low 32 bits
    assign word = (op.inst_class == cls_op_imm_w) || (op.inst_class == cls_op_w);

    // 5-bit shift amount for words
    assign sh_amt = word ? {1'b0, op.op_b[shamt_w32-1:0]} : op.op_b[shamt_w-1:0];

    // low word extended so right shifts see a 32-bit value
    // sign fill for sra, zero fill otherwise
    always_comb begin
        if (!word) begin
            shift_src = op.op_a;
        end else if (op.alu_op == alu_sra) begin
            shift_src = {{(xlen-32){op.op_a[31]}}, op.op_a[31:0]};
        end else begin
            shift_src = {{(xlen-32){1'b0}}, op.op_a[31:0]};
        end
    end

    always_comb begin
        case (op.alu_op)
            alu_add:  alu_result = op.op_a + op.op_b;
            alu_sub:  alu_result = op.op_a - op.op_b;
            alu_slt:  begin
                alu_result = {{(xlen-1){1'b0}}, $signed(op.op_a) < $signed(op.op_b)};
            end
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, op.op_a < op.op_b};
            alu_and:  alu_result = op.op_a & op.op_b;
            alu_or:   alu_result = op.op_a | op.op_b;
            alu_xor:  alu_result = op.op_a ^ op.op_b;
            // sllw keeps only the low word later, upper bits are don't care
            alu_sll:  alu_result = shift_src << sh_amt;
            alu_srl:  alu_result = shift_src >> sh_amt;
            alu_sra:  alu_result = xword_t'($signed(shift_src) >>> sh_amt);
            default:  alu_result = op.op_a + op.op_b;
        endcase
    end

endmodule

`default_nettype wire

// File: source/exu_operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exu_operand_decode (
    input  wire                  valid_q,
    input  exu_pkg::inst_class_e inst_class_q,
    input  exu_pkg::funct3_t     funct3_q,
    input  exu_pkg::reg_idx_t    rs1_q,
    input  exu_pkg::reg_idx_t    rs2_q,
    input  exu_pkg::xword_t      pc_q,
    input  exu_pkg::xword_t      src_a_q,
    input  exu_pkg::xword_t      src_b_q,
    input  exu_pkg::xword_t      imm_q,
    input  wire                  mem_writing_gpr,
    input  exu_pkg::reg_idx_t    mem_rd,
    input  exu_pkg::xword_t      mem_data,
    input  wire                  wb_writing_gpr,
    input  exu_pkg::reg_idx_t    wb_rd,
    input  exu_pkg::xword_t      wb_data,
    exu_op_if.decode_mp          op
);
    import exu_pkg::*;

    logic uses_rs2;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;
    logic is_shift;
    logic alt;
    xword_t src1;
    xword_t src2;
    xword_t op_b;
    alu_op_e alu_op;

    // only register-register forms read rs2
    assign uses_rs2 = (inst_class_q == cls_branch) || (inst_class_q == cls_op) ||
                      (inst_class_q == cls_op_w);

    // x0 is hardwired, never take a bypass for it
    assign rs1_mem_hit = mem_writing_gpr && (mem_rd == rs1_q) && (rs1_q != '0);
    assign rs1_wb_hit  = wb_writing_gpr && (wb_rd == rs1_q) && (rs1_q != '0);
    assign rs2_mem_hit = uses_rs2 && mem_writing_gpr && (mem_rd == rs2_q) && (rs2_q != '0);
    assign rs2_wb_hit  = uses_rs2 && wb_writing_gpr && (wb_rd == rs2_q) && (rs2_q != '0);

    // mem is younger than wb, so it takes priority
    assign src1 = rs1_mem_hit ? mem_data : (rs1_wb_hit ? wb_data : src_a_q);
    assign src2 = rs2_mem_hit ? mem_data : (rs2_wb_hit ? wb_data : src_b_q);

    assign is_shift = (funct3_q == f3_sll) || (funct3_q == f3_sr);
    // instruction bit 30, carried in imm bit 10
    assign alt = imm_q[10];

    // operand b
    always_comb begin
        case (inst_class_q)
            cls_jal: op_b = xword_t'(pc_step);
            cls_lui, cls_auipc, cls_jalr: op_b = imm_q;
            cls_op_imm: begin
                // shamt field only, drop the funct6 bits above it
                op_b = is_shift ? {{(xlen-shamt_w){1'b0}}, imm_q[shamt_w-1:0]} : imm_q;
            end
            cls_op_imm_w: begin
                op_b = is_shift ? {{(xlen-shamt_w32){1'b0}}, imm_q[shamt_w32-1:0]} : imm_q;
            end
            cls_op: begin
                op_b = is_shift ? {{(xlen-shamt_w){1'b0}}, src2[shamt_w-1:0]} : src2;
            end
            cls_op_w: begin
                op_b = is_shift ? {{(xlen-shamt_w32){1'b0}}, src2[shamt_w32-1:0]} : src2;
            end
            default: op_b = src2;
        endcase
    end

    // alu operation from funct3 and alt
    always_comb begin
        alu_op = alu_add;
        case (inst_class_q)
            // compare by subtraction
            cls_branch: alu_op = alu_sub;
            cls_op_imm, cls_op, cls_op_imm_w, cls_op_w: begin
                case (funct3_q)
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_sr:   alu_op = alt ? alu_sra : alu_srl;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: begin
                        // addi has no sub form, imm bit 10 is just data there
                        if (alt && (inst_class_q == cls_op || inst_class_q == cls_op_w)) begin
                            alu_op = alu_sub;
                        end
                    end
                endcase
            end
            default: alu_op = alu_add;
        endcase
    end

    assign op.valid      = valid_q;
    assign op.inst_class = inst_class_q;
    assign op.funct3     = funct3_q;
    assign op.pc         = pc_q;
    assign op.imm        = imm_q;
    assign op.src1       = src1;
    assign op.src2       = src2;
    // operand a: zero for lui, pc for auipc and jal
    assign op.op_a = (inst_class_q == cls_lui) ? '0 :
                     ((inst_class_q == cls_auipc || inst_class_q == cls_jal) ? pc_q : src1);
    assign op.op_b   = op_b;
    assign op.alu_op = alu_op;

endmodule

`default_nettype wire

// File: source/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 branch_flush,
    input  wire                 ready_ex_mem,
    input  wire                 valid_in,
    input  exu_pkg::inst_t      inst_in,
    input  exu_pkg::inst_class_e inst_class_in,
    input  exu_pkg::funct3_t    funct3_in,
    input  exu_pkg::reg_idx_t   rd_in,
    input  exu_pkg::reg_idx_t   rs1_in,
    input  exu_pkg::reg_idx_t   rs2_in,
    input  exu_pkg::xword_t     pc_in,
    input  exu_pkg::xword_t     src_a_in,
    input  exu_pkg::xword_t     src_b_in,
    input  exu_pkg::xword_t     imm_in,
    output logic                valid_q,
    output exu_pkg::inst_t      inst_q,
    output exu_pkg::inst_class_e inst_class_q,
    output exu_pkg::funct3_t    funct3_q,
    output exu_pkg::reg_idx_t   rd_q,
    output exu_pkg::reg_idx_t   rs1_q,
    output exu_pkg::reg_idx_t   rs2_q,
    output exu_pkg::xword_t     pc_q,
    output exu_pkg::xword_t     src_a_q,
    output exu_pkg::xword_t     src_b_q,
    output exu_pkg::xword_t     imm_q
);
    import exu_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            inst_q       <= '0;
            inst_class_q <= cls_none;
            funct3_q     <= '0;
            rd_q         <= '0;
            rs1_q        <= '0;
            rs2_q        <= '0;
            pc_q         <= '0;
            src_a_q      <= '0;
            src_b_q      <= '0;
            imm_q        <= '0;
        end else begin
            // flush wins over a stall, kills the slot on this edge
            if (branch_flush) begin
                valid_q <= 1'b0;
            end else if (ready_ex_mem) begin
                valid_q <= valid_in;
            end
            // payload only moves when downstream takes the current one
            // after a flush its value no longer matters
            if (ready_ex_mem) begin
                inst_q       <= inst_in;
                inst_class_q <= inst_class_in;
                funct3_q     <= funct3_in;
                rd_q         <= rd_in;
                rs1_q        <= rs1_in;
                rs2_q        <= rs2_in;
                pc_q         <= pc_in;
                src_a_q      <= src_a_in;
                src_b_q      <= src_b_in;
                imm_q        <= imm_in;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/exu_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exu_op_if;
    import exu_pkg::*;

    // one decoded instruction, levels only, meaningful while valid is high
    logic valid;
    inst_class_e inst_class;
    funct3_t funct3;
    xword_t pc;
    xword_t imm;

    // register values after forwarding
    xword_t src1;
    xword_t src2;

    // alu inputs and operation
    xword_t op_a;
    xword_t op_b;
    alu_op_e alu_op;

    // decode side drives everything
    modport decode_mp (
        output valid, inst_class, funct3, pc, imm,
        output src1, src2, op_a, op_b, alu_op
    );

    // alu and result select only read
    modport use_mp (
        input valid, inst_class, funct3, pc, imm,
        input src1, src2, op_a, op_b, alu_op
    );

endinterface

`default_nettype wire

// File: source/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // datapath width of the rv64 core
    localparam int xlen = 64;

    // sequential pc increment, no compressed instructions
    localparam int pc_step = 4;

    // shift amount widths, full and word variants
    localparam int shamt_w = 6;
    localparam int shamt_w32 = 5;

    typedef logic [xlen-1:0] xword_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] funct3_t;
    typedef logic [31:0] inst_t;

    // branch funct3 codes
    localparam funct3_t f3_beq = 3'b000;
    localparam funct3_t f3_bne = 3'b001;
    localparam funct3_t f3_blt = 3'b100;
    localparam funct3_t f3_bge = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // arithmetic funct3 codes
    // add/sub is 000 and falls to the default decode
    localparam funct3_t f3_sll = 3'b001;
    localparam funct3_t f3_slt = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor = 3'b100;
    // srl and sra share a code, split by the alt bit
    localparam funct3_t f3_sr = 3'b101;
    localparam funct3_t f3_or = 3'b110;
    localparam funct3_t f3_and = 3'b111;

    // instruction class as delivered by decode
    typedef enum logic [3:0] {
        cls_none,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_op_imm,
        cls_op,
        cls_op_imm_w,
        cls_op_w
    } inst_class_e;

    // alu operation select
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

endpackage

`default_nettype wire
